// File: verification/vdc_cases.txt
# name scroll_x scroll_y frames hsync_low_clks line_clks vsync_low_lines frame_lines
# Scroll in pixels, decimal; the last four columns are the expected raster counts
no_scroll    0     0    2  16  88  2  13
coarse_x     16    0    2  16  88  2  13
coarse_y     0     24   2  16  88  2  13
coarse_xy    72    40   2  16  88  2  13
fine_x       3     0    2  16  88  2  13
fine_y       0     5    2  16  88  2  13
fine_xy      13    22   2  16  88  2  13
fine_x7      7     7    3  16  88  2  13
wrap_x       250   0    2  16  88  2  13
wrap_xy      1020  1019 2  16  88  2  13

// File: project.f
logic/vdc_pkg.sv
logic/raster_if.sv
logic/tile_bus_if.sv
logic/raster_timing.sv
logic/bg_fetch.sv
logic/tile_slot.sv
logic/pixel_output.sv
logic/vdc_huc6270.sv
verification/vdc_tb.sv

// File: verification/vdc_tb.sv
`timescale 1ns/100ps

module vdc_tb import vdc_pkg::*; ();

  //////////////////////////////////////////////////
  // Raster geometry of the small test raster

  localparam int HSW = 1;
  localparam int HDS = 2;
  localparam int HDW = 3;
  localparam int HDE = 1;
  localparam int VSW = 1;
  localparam int VDS = 1;
  localparam int VDW = 5;
  localparam int VDE = 2;

  localparam int LINE_CLKS    = 8 * (HSW + HDS + HDW + HDE + 4);        // 88 clocks
  localparam int FRAME_LINES  = (VDS + 2) + (VDW + 1) + VDE + (VSW + 1);  // 13 lines
  localparam int FRAME_CLKS   = LINE_CLKS * FRAME_LINES;
  localparam int FIRST_ROW    = VDS + 2;             // V_WAIT comes first after reset
  localparam int DISP_START   = 8 * (HSW + HDS + 2); // First H_DISP clock of a line
  localparam int DISP_CLKS    = 8 * (HDW + 1);
  localparam int BAT_CHECK_H  = DISP_START + 17;     // Cycle 1 of the third display character
  localparam int RESET_CYCLES = 5;
  localparam int PAT_TILE0    = 64;                  // Patterns start at word 1024
  localparam int PAT_TILES    = 64;

  logic       clock;
  logic       reset_N;
  scroll_t    scroll_x;
  scroll_t    scroll_y;
  vram_word_t vram_data = '0;   // VRAM answer bus
  vram_addr_t vram_addr;
  logic       hsync_n;
  logic       vsync_n;
  pixel_t     vd;

  vram_word_t  vram [65536];    // External VRAM contents
  vram_addr_t  addr_q = '0;     // Address seen at the last rising edge
  logic [31:0] lcg_state = 32'h8c610bc1;
  int          cycle_cnt = 0;
  int          cycle_limit = 0; // Set once the cases are known
  string       cur_case = "setup";

  // Case table
  string case_name [$];
  int    case_sx [$];
  int    case_sy [$];
  int    case_frames [$];
  int    case_hs [$];           // Hsync low clocks
  int    case_line [$];         // Clocks per line
  int    case_vs [$];           // Vsync low lines
  int    case_flines [$];       // Lines per frame

  vdc_huc6270 #(
    .HSW(HSW), .HDS(HDS), .HDW(HDW), .HDE(HDE),
    .VSW(VSW), .VDS(VDS), .VDW(VDW), .VDE(VDE)
  ) dut0 (
    .clock     (clock),
    .reset_N   (reset_N),
    .scroll_x  (scroll_x),
    .scroll_y  (scroll_y),
    .vram_data (vram_data),
    .vram_addr (vram_addr),
    .hsync_n   (hsync_n),
    .vsync_n   (vsync_n),
    .vd        (vd)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;   // 40 ns period
  end

  // Synchronous VRAM with data one clock after the address
  always @(posedge clock) addr_q <= vram_addr;
  always @(negedge clock) vram_data <= vram[addr_q];

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Simulation timed out after %0d clocks", cycle_cnt);
      $display("TEST FAIL");
      $fatal(1, "watchdog expired");
    end
  end

  //////////////////////////////////////////////////
  // Reference model and helpers

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Background point of the 256x256 pixel map
  function automatic pixel_t bg_pixel(int x, int y);
    vram_word_t bat;
    vram_word_t cg0;
    vram_word_t cg1;
    color_t     pix;
    int         xm;
    int         ym;
    int         base;
    int         b;
    xm   = x & 255;
    ym   = y & 255;
    bat  = vram[((ym >> 3) << 5) + (xm >> 3)];   // 32 entries per map row
    base = int'(bat[11:0]) * 16 + (ym & 7);      // 16 words per tile
    cg0  = vram[base];
    cg1  = vram[base + 8];                       // CG1 plane 8 words on
    b    = xm & 7;                               // Leftmost pixel in the MSB
    pix  = {cg1[15 - b], cg1[7 - b], cg0[15 - b], cg0[7 - b]};
    if (pix == '0) return '0;                    // Transparent keeps palette 0
    return {1'b0, bat[15:12], pix};
  endfunction

  task automatic stop_on_error(string msg);
    $display("%s in case %s", msg, cur_case);
    $display("TEST FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_count(string what, int expected, int actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected %0d, actual %0d", cur_case, what, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_pixel(string what, pixel_t expected, pixel_t actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected 0x%03h, actual 0x%03h", cur_case, what, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "pixel mismatch");
    end
  endtask

  task automatic check_addr(string what, vram_addr_t expected, vram_addr_t actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected 0x%04h, actual 0x%04h", cur_case, what, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic fill_vram();
    logic [31:0] rnd;
    int          a;
    for (a = 0; a < 65536; a++) begin
      vram[a] = vram_word_t'(a * 40503 + 12345);   // Whole-address fill outside the map
    end
    for (a = 0; a < 1024; a++) begin              // BAT entries with tiles in the pattern region
      rnd     = lcg_next();
      vram[a] = {rnd[31:28], 12'(PAT_TILE0 + (int'(rnd[23:16]) & (PAT_TILES - 1)))};
    end
    for (a = 0; a < PAT_TILES * 16; a++) begin
      rnd                       = lcg_next();
      vram[PAT_TILE0 * 16 + a]  = rnd[31:16];
    end
  endtask

  task automatic read_cases();
    int    fd;
    int    n;
    int    ch;
    int    v [7];
    logic  done;
    string tok;
    done = 1'b0;
    fd   = $fopen("verification/vdc_cases.txt", "r");
    if (fd == 0) stop_on_error("Cannot open verification/vdc_cases.txt");
    while (!done) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        done = 1'b1;
      end else if (tok.substr(0, 0) == "#") begin
        ch = $fgetc(fd);                          // Drop the rest of a comment line
        while (ch != 10 && ch != -1) ch = $fgetc(fd);
      end else begin
        n = $fscanf(fd, "%d %d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
        if (n != 7) stop_on_error({"Malformed case line starting with ", tok});
        case_name.push_back(tok);
        case_sx.push_back(v[0]);
        case_sy.push_back(v[1]);
        case_frames.push_back(v[2]);
        case_hs.push_back(v[3]);
        case_line.push_back(v[4]);
        case_vs.push_back(v[5]);
        case_flines.push_back(v[6]);
      end
    end
    $fclose(fd);
    if (case_name.size() == 0) stop_on_error("Case file holds no cases");
  endtask

  //////////////////////////////////////////////////
  // Reset and every clock of one case's frames

  task automatic run_case(int idx);
    int         sx;
    int         sy;
    int         k;
    int         h;
    int         fl;
    int         r;
    int         c;
    int         last_hfall;
    int         last_vfall;
    int         hs_low;
    int         vs_low;
    int         n_hpulse;
    int         n_line;
    int         n_vpulse;
    int         n_frame;
    logic       on_row;
    logic       h_open;
    logic       v_open;
    logic       prev_hs;
    logic       prev_vs;
    pixel_t     exp_vd;
    vram_addr_t exp_addr;
    cur_case = case_name[idx];
    sx       = case_sx[idx];
    sy       = case_sy[idx];
    @(negedge clock);
    reset_N  = 1'b0;
    scroll_x = scroll_t'(sx);
    scroll_y = scroll_t'(sy);
    repeat (RESET_CYCLES) @(negedge clock);
    check_count("hsync_n in reset", 0, int'(hsync_n));
    check_count("vsync_n in reset", 1, int'(vsync_n));
    check_pixel("vd in reset", '0, vd);
    check_addr("vram_addr in reset", '0, vram_addr);
    reset_N    = 1'b1;                        // Position 0 is H_SYNC character 0
    last_hfall = -1;
    last_vfall = -1;
    hs_low     = 0;
    vs_low     = 0;
    n_hpulse   = 0;
    n_line     = 0;
    n_vpulse   = 0;
    n_frame    = 0;
    h_open     = 1'b0;
    v_open     = 1'b0;
    prev_hs    = hsync_n;
    prev_vs    = vsync_n;
    for (k = 1; k <= case_frames[idx] * FRAME_CLKS; k++) begin
      @(negedge clock);                       // Outputs settled mid-cycle
      h      = k % LINE_CLKS;
      fl     = (k / LINE_CLKS) % FRAME_LINES;
      r      = fl - FIRST_ROW;
      on_row = (r >= 0) && (r <= VDW);
      c      = h - DISP_START;
      exp_vd = '0;
      if (on_row && c >= 0 && c < DISP_CLKS) exp_vd = bg_pixel(c + sx, r + sy);
      check_pixel($sformatf("vd line %0d clock %0d", fl, h), exp_vd, vd);
      if (on_row && h == BAT_CHECK_H) begin
        // Fifth fetched character as two lead-in fetches come from H_WAIT
        exp_addr = vram_addr_t'(((((r + sy) >> 3) & 31) << 5) + (((sx >> 3) + 4) & 31));
        check_addr($sformatf("BAT address row %0d", r), exp_addr, vram_addr);
      end else if (!on_row) begin
        check_addr($sformatf("vram_addr line %0d", fl), '0, vram_addr);
      end
      if (prev_hs && !hsync_n) begin          // Hsync falling edge
        if (last_hfall >= 0) begin
          check_count("line clocks", case_line[idx], k - last_hfall);
          n_line++;
        end
        last_hfall = k;
        h_open     = 1'b1;
        hs_low     = 0;
      end else if (!prev_hs && hsync_n && h_open) begin
        check_count("hsync low clocks", case_hs[idx], hs_low);
        n_hpulse++;
        h_open = 1'b0;
      end
      if (!hsync_n) hs_low++;
      if (prev_vs && !vsync_n) begin          // Vsync falling edge
        if (last_vfall >= 0) begin
          check_count("frame clocks", case_flines[idx] * case_line[idx], k - last_vfall);
          n_frame++;
        end
        last_vfall = k;
        v_open     = 1'b1;
        vs_low     = 0;
      end else if (!prev_vs && vsync_n && v_open) begin
        check_count("vsync low clocks", case_vs[idx] * case_line[idx], vs_low);
        n_vpulse++;
        v_open = 1'b0;
      end
      if (!vsync_n) vs_low++;
      prev_hs = hsync_n;
      prev_vs = vsync_n;
    end
    if (n_hpulse == 0 || n_line == 0) stop_on_error("No complete hsync pulse and line seen");
    if (n_vpulse == 0 || n_frame == 0) stop_on_error("No complete vsync pulse and frame seen");
  endtask

  initial begin
    int i;
    reset_N  = 1'b0;
    scroll_x = '0;
    scroll_y = '0;
    fill_vram();
    read_cases();
    foreach (case_frames[j]) cycle_limit += case_frames[j] * FRAME_CLKS * 2;
    for (i = 0; i < case_name.size(); i++) begin
      run_case(i);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule : vdc_tb

// File: logic/vdc_huc6270.sv
`timescale 1ns/100ps

module vdc_huc6270 import vdc_pkg::*; #(
  parameter logic [4:0] HSW = 5'd2,
  parameter logic [6:0] HDS = 7'd2,
  parameter logic [6:0] HDW = 7'd31,
  parameter logic [3:0] HDE = 4'd3,
  parameter logic [4:0] VSW = 5'd2,
  parameter logic [7:0] VDS = 8'd15,
  parameter logic [8:0] VDW = 9'd239,
  parameter logic [7:0] VDE = 8'd3
) (
  input  logic       clock,
  input  logic       reset_N,
  input  scroll_t    scroll_x,
  input  scroll_t    scroll_y,
  input  vram_word_t vram_data,   // Answers vram_addr one clock later
  output vram_addr_t vram_addr,
  output logic       hsync_n,
  output logic       vsync_n,
  output pixel_t     vd
);

  raster_if   raster ();
  tile_bus_if tile_bus ();

  char_cycle_t fine_x;
  char_cycle_t column;
  palette_t    slot_palette [BG_SLOTS];
  color_t      slot_pixel [BG_SLOTS];

  raster_timing #(
    .HSW(HSW), .HDS(HDS), .HDW(HDW), .HDE(HDE),
    .VSW(VSW), .VDS(VDS), .VDW(VDW), .VDE(VDE)
  ) timing0 (
    .clock   (clock),
    .reset_N (reset_N),
    .timing  (raster.timing),
    .hsync_n (hsync_n),
    .vsync_n (vsync_n)
  );

  bg_fetch #(.HDW(HDW)) fetch0 (
    .clock     (clock),
    .reset_N   (reset_N),
    .scroll_x  (scroll_x),
    .scroll_y  (scroll_y),
    .vram_data (vram_data),
    .raster    (raster.fetch),
    .slots     (tile_bus.fetch),
    .vram_addr (vram_addr),
    .fine_x    (fine_x)
  );

  // Tile line ring
  for (genvar i = 0; i < BG_SLOTS; i++) begin : g_slot
    tile_slot #(.SLOT_INDEX(i)) slot0 (
      .clock   (clock),
      .reset_N (reset_N),
      .load    (tile_bus.slot),
      .column  (column),
      .palette (slot_palette[i]),
      .pixel   (slot_pixel[i])
    );
  end

  pixel_output #(.HDW(HDW)) output0 (
    .clock        (clock),
    .reset_N      (reset_N),
    .raster       (raster.pixel_out),
    .fine_x       (fine_x),
    .slot_palette (slot_palette),
    .slot_pixel   (slot_pixel),
    .column       (column),
    .vd           (vd)
  );

endmodule : vdc_huc6270

// File: logic/pixel_output.sv
`timescale 1ns/100ps

module pixel_output import vdc_pkg::*; #(
  parameter logic [6:0] HDW   // Display width in characters, minus one
) (
  input  logic         clock,
  input  logic         reset_N,
  raster_if.pixel_out  raster,
  input  char_cycle_t  fine_x,
  input  palette_t     slot_palette [BG_SLOTS],
  input  color_t       slot_pixel [BG_SLOTS],
  output char_cycle_t  column,    // Tile column of the next pixel
  output pixel_t       vd
);

  localparam raster_cnt_t LAST_X = {HDW, 3'd7};  // Rightmost display column

  raster_cnt_t x_pos;      // Display column of this clock
  slot_idx_t   rd_ptr;     // Slot holding the next pixel
  logic        next_disp;  // Next clock shows a display pixel
  palette_t    pal_shown;
  color_t      pix;

  assign x_pos = {HDW - raster.h_cnt[6:0], raster.char_cycle};

  always_comb begin
    next_disp = 1'b0;
    if (raster.v_state == V_DISP) begin
      if (raster.h_state == H_WAIT) begin
        next_disp = (raster.h_cnt == '0) && (raster.char_cycle == 3'd7);
      end else if (raster.h_state == H_DISP) begin
        next_disp = (x_pos != LAST_X);
      end
    end
  end

  // One clock ahead so vd is registered yet lines up with the display
  assign column = raster.char_cycle + 3'd1 + fine_x;  // Wraps mod 8

  assign pix       = slot_pixel[rd_ptr];
  assign pal_shown = (pix == '0) ? '0 : slot_palette[rd_ptr];  // Colour 0 is transparent

  //////////////////////////////////////////////////
  // Read ring and pixel register

  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      rd_ptr <= '0;
      vd     <= '0;
    end else if (next_disp) begin
      vd <= {1'b0, pal_shown, pix};   // Bit 8 low for background
      if (column == 3'd7) begin       // Next lookup crosses into the next tile
        rd_ptr <= (rd_ptr == slot_idx_t'(BG_SLOTS - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end else begin
      rd_ptr <= '0;                   // Each line starts at slot 0
      vd     <= '0;                   // Blank outside display
    end
  end

endmodule : pixel_output

// File: logic/tile_slot.sv
`timescale 1ns/100ps

module tile_slot import vdc_pkg::*; #(
  parameter int SLOT_INDEX     // Position in the slot ring
) (
  input  logic        clock,
  input  logic        reset_N,
  tile_bus_if.slot    load,
  input  char_cycle_t column,  // Pixel within the tile line, leftmost is 0
  output palette_t    palette,
  output color_t      pixel
);

  vram_word_t cg0;
  vram_word_t cg1;
  vram_word_t cg1_now;  // CG1 as the output stage sees it
  logic       sel;

  assign sel = (load.slot_sel == slot_idx_t'(SLOT_INDEX));

  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      palette <= '0;
      cg0     <= '0;
      cg1     <= '0;
    end else if (sel) begin
      if (load.palette_we) palette <= palette_t'(load.word[15:12]);  // BAT palette field
      if (load.cg0_we)     cg0     <= load.word;
      if (load.cg1_we)     cg1     <= load.word;
    end
  end

  // CG1 arrives in the same clock that may look up this tile's first pixel
  assign cg1_now = (sel && load.cg1_we) ? load.word : cg1;

  // Bitplanes 3..0 with the leftmost pixel in each MSB
  assign pixel = {cg1_now[4'd15 - column], cg1_now[3'd7 - column],
                  cg0[4'd15 - column], cg0[3'd7 - column]};

endmodule : tile_slot

// File: logic/bg_fetch.sv
`timescale 1ns/100ps

module bg_fetch import vdc_pkg::*; #(
  parameter logic [6:0] HDW   // Display width in characters, minus one
) (
  input  logic        clock,
  input  logic        reset_N,
  input  scroll_t     scroll_x,
  input  scroll_t     scroll_y,
  input  vram_word_t  vram_data,
  raster_if.fetch     raster,
  tile_bus_if.fetch   slots,
  output vram_addr_t  vram_addr,
  output char_cycle_t fine_x      // Pixel offset into the first tile
);

  scroll_t    x_start;    // Scroll X for this line
  scroll_t    y_start;    // Scroll Y for this line
  scroll_t    cur_row;    // Display line within the frame
  scroll_t    bg_y;       // Map line being drawn
  logic [4:0] map_row;    // BAT row of this line
  logic [4:0] start_col;  // BAT column of the first fetch
  logic [4:0] fetch_char; // Characters fetched so far on this line
  logic [4:0] tile_col;
  vram_addr_t bat_ptr;
  vram_addr_t tile_ptr;   // CG0 word of the tile line
  slot_idx_t  wr_ptr;
  logic       do_fetch;
  logic       sync_last;  // Last clock of H_SYNC
  logic       disp_last;  // Last clock of H_DISP

  assign sync_last = (raster.h_state == H_SYNC) && (raster.h_cnt == '0) &&
                     (raster.char_cycle == 3'd7);
  assign disp_last = (raster.h_state == H_DISP) && (raster.h_cnt == '0) &&
                     (raster.char_cycle == 3'd7);

  // Two characters ahead of the display, on display lines only
  assign do_fetch = (raster.v_state == V_DISP) &&
                    ((raster.h_state == H_DISP) ||
                     ((raster.h_state == H_WAIT) && (raster.h_cnt < 10'd2)));

  assign bg_y   = cur_row + y_start;
  assign fine_x = x_start[2:0];

  //////////////////////////////////////////////////
  // BAT addressing

  always_comb begin
    if (raster.h_state == H_WAIT) begin
      fetch_char = 5'd1 - raster.h_cnt[4:0];          // The two lead-in characters
    end else begin
      fetch_char = 5'(HDW) - raster.h_cnt[4:0] + 5'd2;
    end
  end

  assign tile_col = start_col + fetch_char;           // Wraps around the 32 wide map
  assign bat_ptr  = (vram_addr_t'(map_row) << BAT_ROW_SHIFT) + vram_addr_t'(tile_col);

  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      x_start   <= '0;
      y_start   <= '0;
      cur_row   <= '0;
      map_row   <= '0;
      start_col <= '0;
    end else begin
      if ((raster.h_state == H_SYNC) && (raster.h_cnt == '0) &&
          (raster.char_cycle == 3'd6)) begin
        x_start <= scroll_x;                          // Once per line
        y_start <= scroll_y;
      end
      if (raster.v_state == V_WAIT) begin
        cur_row <= '0;
      end else if (disp_last) begin
        cur_row <= cur_row + 1'b1;
      end
      if (sync_last) begin
        map_row   <= bg_y[7:3];
        start_col <= x_start[7:3];
      end
    end
  end

  // Pattern line of the tile named by the BAT word
  always_ff @(posedge clock) begin
    if (do_fetch && (raster.char_cycle == 3'd2)) begin
      tile_ptr <= vram_addr_t'(vram_data[11:0] * TILE_WORDS + bg_y[2:0]);
    end
  end

  always_comb begin
    vram_addr = '0;
    if (do_fetch) begin
      case (raster.char_cycle)
        3'd1:    vram_addr = bat_ptr;                 // BAT entry
        3'd5:    vram_addr = tile_ptr;                // CG0
        3'd7:    vram_addr = tile_ptr + vram_addr_t'(CG1_OFFSET);
        default: vram_addr = '0;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Slot loading

  // CG1 at clock 0 belongs to the previous character, so the first one is junk
  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      wr_ptr <= slot_idx_t'(BG_SLOTS - 1);
    end else if (!do_fetch) begin
      wr_ptr <= slot_idx_t'(BG_SLOTS - 1);
    end else if (raster.char_cycle == 3'd0) begin
      wr_ptr <= (wr_ptr == slot_idx_t'(BG_SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
    end
  end

  assign slots.slot_sel   = wr_ptr;
  assign slots.word       = vram_data;
  assign slots.palette_we = do_fetch && (raster.char_cycle == 3'd2);
  assign slots.cg0_we     = do_fetch && (raster.char_cycle == 3'd6);
  assign slots.cg1_we     = do_fetch && (raster.char_cycle == 3'd0);

endmodule : bg_fetch

// File: logic/raster_timing.sv
`timescale 1ns/100ps

module raster_timing import vdc_pkg::*; #(
  parameter logic [4:0] HSW,  // Hsync width in characters, minus one
  parameter logic [6:0] HDS,  // Left blanking in characters, minus one
  parameter logic [6:0] HDW,  // Display width in characters, minus one
  parameter logic [3:0] HDE,  // Right blanking in characters, minus one
  parameter logic [4:0] VSW,  // Vsync width in lines, minus one
  parameter logic [7:0] VDS,  // Top blanking in lines, minus two
  parameter logic [8:0] VDW,  // Display height in lines, minus one
  parameter logic [7:0] VDE   // Bottom blanking in lines
) (
  input  logic     clock,
  input  logic     reset_N,
  raster_if.timing timing,
  output logic     hsync_n,
  output logic     vsync_n
);

  char_cycle_t char_cycle;
  h_state_t    h_state;
  v_state_t    v_state;
  raster_cnt_t h_cnt;
  raster_cnt_t v_cnt;    // Lines left in the vertical period, minus one
  logic        char_end; // Last clock of a character
  logic        eol;      // Last clock of a line

  assign char_end = (char_cycle == 3'd7);
  assign eol      = char_end && (h_state == H_END) && (h_cnt == '0);

  // Free running character clock
  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      char_cycle <= '0;
    end else begin
      char_cycle <= char_cycle + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Horizontal periods

  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      h_state <= H_SYNC;                 // Line starts in sync
      h_cnt   <= raster_cnt_t'(HSW);
    end else if (char_end) begin
      if (h_cnt != '0) begin
        h_cnt <= h_cnt - 1'b1;           // Count down characters
      end else begin
        case (h_state)
          H_SYNC: begin
            h_state <= H_WAIT;
            h_cnt   <= raster_cnt_t'(HDS);
          end
          H_WAIT: begin
            h_state <= H_DISP;
            h_cnt   <= raster_cnt_t'(HDW);
          end
          H_DISP: begin
            h_state <= H_END;
            h_cnt   <= raster_cnt_t'(HDE);
          end
          default: begin                 // H_END wraps to the next line
            h_state <= H_SYNC;
            h_cnt   <= raster_cnt_t'(HSW);
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Vertical periods stepped once per line

  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      v_state <= V_WAIT;
      v_cnt   <= raster_cnt_t'(VDS) + 1'b1;  // VDS+2 lines of top blanking
    end else if (eol) begin
      if (v_cnt != '0) begin
        v_cnt <= v_cnt - 1'b1;
      end else begin
        case (v_state)
          V_WAIT: begin
            v_state <= V_DISP;
            v_cnt   <= raster_cnt_t'(VDW);
          end
          V_DISP: begin
            v_state <= V_END;
            v_cnt   <= raster_cnt_t'(VDE) - 1'b1;  // VDE lines
          end
          V_END: begin
            v_state <= V_SYNC;
            v_cnt   <= raster_cnt_t'(VSW);
          end
          default: begin                 // End of sync starts a new frame
            v_state <= V_WAIT;
            v_cnt   <= raster_cnt_t'(VDS) + 1'b1;
          end
        endcase
      end
    end
  end

  assign hsync_n = (h_state != H_SYNC);  // Active low
  assign vsync_n = (v_state != V_SYNC);

  assign timing.char_cycle = char_cycle;
  assign timing.h_state    = h_state;
  assign timing.v_state    = v_state;
  assign timing.h_cnt      = h_cnt;

endmodule : raster_timing

// File: logic/tile_bus_if.sv
`timescale 1ns/100ps

// Load path from the background fetch into the tile slots
interface tile_bus_if import vdc_pkg::*; ();

  slot_idx_t  slot_sel;    // Slot being filled
  logic       palette_we;  // BAT word on word, keep its palette
  logic       cg0_we;      // CG0 plane word on word
  logic       cg1_we;      // CG1 plane word on word
  vram_word_t word;        // Word returned by VRAM

  modport fetch (
    output slot_sel, palette_we, cg0_we, cg1_we, word
  );

  modport slot (
    input slot_sel, palette_we, cg0_we, cg1_we, word
  );

endinterface : tile_bus_if

// File: logic/raster_if.sv
`timescale 1ns/100ps

// Raster position, shared by the timing generator, fetch and output stages
interface raster_if import vdc_pkg::*; ();

  char_cycle_t char_cycle;  // Clock within the current character
  h_state_t    h_state;     // Horizontal period
  v_state_t    v_state;     // Vertical period
  raster_cnt_t h_cnt;       // Characters left in the horizontal period, minus one

  modport timing (
    output char_cycle, h_state, v_state, h_cnt
  );

  modport fetch (
    input char_cycle, h_state, v_state, h_cnt
  );

  // Pixel output stage
  modport pixel_out (
    input char_cycle, h_state, v_state, h_cnt
  );

endinterface : raster_if

// File: logic/vdc_pkg.sv
package vdc_pkg;

  //////////////////////////////////////////////////
  // Bus and pixel widths

  typedef logic [15:0] vram_addr_t;   // VRAM word address
  typedef logic [15:0] vram_word_t;   // VRAM data word

  // Pixel word {sprite flag, palette, colour}
  typedef logic [8:0]  pixel_t;
  typedef logic [3:0]  palette_t;     // BAT palette number
  typedef logic [3:0]  color_t;       // Colour index within palette

  typedef logic [2:0]  char_cycle_t;  // Clock within an 8-clock character
  typedef logic [9:0]  scroll_t;      // Scroll position in pixels
  typedef logic [9:0]  raster_cnt_t;  // Period down-counter

  //////////////////////////////////////////////////
  // Raster period states

  typedef enum logic [1:0] {
    H_SYNC,   // Horizontal sync pulse
    H_WAIT,   // Left blanking
    H_DISP,   // Active pixels
    H_END     // Right blanking
  } h_state_t;

  typedef enum logic [1:0] {
    V_SYNC,   // Vertical sync pulse
    V_WAIT,   // Top blanking
    V_DISP,   // Active lines
    V_END     // Bottom blanking
  } v_state_t;

  //////////////////////////////////////////////////
  // Background fetch constants

  localparam int BG_SLOTS      = 3;   // Tile line slots in the ring
  localparam int BAT_ROW_SHIFT = 5;   // Map is 32 tiles wide
  localparam int CG1_OFFSET    = 8;   // CG1 plane sits 8 words after CG0
  localparam int TILE_WORDS    = 16;  // Words per tile pattern

  typedef logic [$clog2(BG_SLOTS)-1:0] slot_idx_t;  // Index into the slot ring

endpackage : vdc_pkg
